// File: Bender.yml
package:
  name: fprint_unit

sources:
  - common/fprint_pkg.sv
  - source/fprint_fifo.sv
  - source/fprint_apb_front.sv
  - fprint_store/fprint_store.sv
  - source/fprint_comparator.sv
  - source/fprint_unit_top.sv
  - target: test
    files:
      - bench/fprint_unit_sva.sv
      - bench/fprint_unit_tb.sv

// File: bench/fprint_unit_sva.sv
`default_nettype none

module fprint_unit_sva import fprint_pkg::*; (
	input wire logic       clk,
	input wire logic       reset,
	input wire logic       psel,
	input wire logic       penable,
	input wire logic       pready,
	input wire logic       fp_accept,
	input wire logic       fifo_empty,
	input wire logic       task_done,
	input wire task_id_t   done_task,
	input wire task_mask_t checkout_0,
	input wire task_mask_t checkout_1
);

	// a stalled access stays in its access phase until pready
	stall_holds_access: assert property (@(posedge clk) disable iff (reset)
		(psel && penable && !pready) |=> (psel && penable))
		else $error("access phase dropped before pready");

	queued_half_in_fifo: assert property (@(posedge clk) disable iff (reset)
		(fp_accept && pready) |=> !fifo_empty)
		else $error("accepted fingerprint half missing from the fifo");

	// completion wins over a same-cycle checkout of that task
	done_clears_checkout: assert property (@(posedge clk) disable iff (reset)
		task_done |=> (!checkout_0[$past(done_task)] && !checkout_1[$past(done_task)]))
		else $error("task_done left its task checked out");

endmodule

bind fprint_apb_front fprint_unit_sva u_sva (
	.clk        (clk),
	.reset      (reset),
	.psel       (psel),
	.penable    (penable),
	.pready     (pready),
	.fp_accept  (fp_accept),
	.fifo_empty (fifo_empty),
	.task_done  (task_done),
	.done_task  (done_task),
	.checkout_0 (checkout_mask[0]),
	.checkout_1 (checkout_mask[1])
);

`default_nettype wire

// File: bench/fprint_unit_tb.sv
`default_nettype none

module fprint_unit_tb import fprint_pkg::*;;

	logic              clk;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic              pready;
	logic              pslverr;
	logic              mismatch;

	logic [36:0]       op_log [$]; // {core, offset, data} of every completed write
	int                errors = 0;
	int                checks = 0;
	int                cycle = 0;
	logic              check_req = 1'b0;
	string             check_name;

	fprint_unit_top uut (
		.clk      (clk),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.mismatch (mismatch)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic stop_on_timeout(input string what);
		errors++;
		$display("timeout: %s", what);
		$display("checks %0d, errors %0d", checks, errors);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic report_fail(input string field, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("Fail %s: %s = %h, expected %h", check_name, field, got, want);
	endtask

	// the slave never signals an error on any access
	task automatic check_no_slverr();
		checks++;
		if (pslverr !== 1'b0) begin
			errors++;
			$display("Fail pslverr = %h, expected %h", pslverr, 1'b0);
		end
	endtask

	task automatic write_reg(input core_t core, input logic [3:0] ofs, input logic [31:0] data);
		int start;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = {3'b000, core, ofs}; // bit 4 picks the logical core
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		start   = cycle;
		@(posedge clk);
		while (!pready && cycle - start < 100) @(posedge clk); // fifo full stalls here
		if (!pready) stop_on_timeout("APB write never saw pready");
		check_no_slverr();
		op_log.push_back({core, ofs, data});
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input core_t core, input logic [3:0] ofs, output logic [31:0] data);
		int start;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = {3'b000, core, ofs};
		@(negedge clk);
		penable = 1'b1;
		start   = cycle;
		@(posedge clk);
		while (!pready && cycle - start < 100) @(posedge clk);
		if (!pready) stop_on_timeout("APB read never saw pready");
		check_no_slverr();
		data = prdata;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic checkout(input core_t core, input task_id_t id);
		write_reg(core, OFS_CS, {27'd0, 1'b1, id});
	endtask

	task automatic checkin(input core_t core, input task_id_t id);
		write_reg(core, OFS_CS, {27'd0, 1'b0, id});
	endtask

	// low block first, the high block closes the entry
	task automatic send_fprint(input core_t core, input task_id_t id, input fprint_t fp);
		write_reg(core, OFS_FPRINT, {fp[15:0], 10'd0, 1'b0, 1'b0, id});
		write_reg(core, OFS_FPRINT, {fp[31:16], 10'd0, 1'b1, 1'b0, id});
	endtask

	// replays the write log, returns {mismatch register, status register}
	function automatic logic [63:0] predict_regs();
		task_mask_t  out_m [NUM_CORES];
		task_mask_t  in_m [NUM_CORES];
		half_t       lo [NUM_CORES];
		logic [35:0] q0 [$]; // {task, fingerprint} per core
		logic [35:0] q1 [$];
		logic [35:0] e0;
		logic [35:0] e1;
		core_t       c;
		logic [3:0]  ofs;
		logic [31:0] d;
		task_id_t    t;
		count_t      mc;
		count_t      mmc;
		task_id_t    last;
		logic        flag;
		for (int k = 0; k < NUM_CORES; k++) begin
			out_m[k] = '0;
			in_m[k]  = '0;
			lo[k]    = '0;
		end
		mc   = '0;
		mmc  = '0;
		last = '0;
		flag = 1'b0;
		foreach (op_log[i]) begin
			{c, ofs, d} = op_log[i];
			t = d[3:0];
			if (ofs == OFS_CS) begin
				if (d[4])
					out_m[c][t] = 1'b1;
				else if (out_m[c][t])
					in_m[c][t] = 1'b1; // checkin needs a checkout
			end else if (ofs == OFS_FPRINT && out_m[c][t]) begin
				if (!d[5])
					lo[c] = d[31:16];
				else if (c == 1'b0)
					q0.push_back({t, d[31:16], lo[c]});
				else
					q1.push_back({t, d[31:16], lo[c]});
			end
			while (q0.size() > 0 && q1.size() > 0) begin
				e0 = q0.pop_front();
				e1 = q1.pop_front();
				if (e0 == e1) begin
					if (mc != 8'hff) mc++;
				end else begin
					if (mmc != 8'hff) mmc++;
					last = e0[35:32];
					flag = 1'b1;
				end
				for (int k = 0; k < NUM_CORES; k++) begin
					out_m[k][e0[35:32]] = 1'b0;
					in_m[k][e0[35:32]]  = 1'b0;
				end
			end
		end
		return {23'd0, flag, 4'd0, last, mmc, mc, in_m[0] & in_m[1]};
	endfunction

	task automatic request_check(input string name);
		int start;
		check_name = name;
		check_req  = 1'b1;
		start      = cycle;
		while (check_req && cycle - start < 1000) @(negedge clk);
		if (check_req) stop_on_timeout({name, ": compare process did not finish"});
	endtask

	// compare process, runs one check per request
	initial begin : compare_proc
		logic [63:0] want;
		logic [31:0] status;
		logic [31:0] mm_reg;
		int          start;
		forever begin
			start = cycle;
			while (!check_req && cycle - start < 5000) @(negedge clk);
			if (!check_req) stop_on_timeout("no check was requested for too long");
			want  = predict_regs();
			start = cycle;
			read_reg(1'b0, OFS_STATUS, status);
			while (status[31:16] != want[31:16] && cycle - start < 500)
				read_reg(1'b0, OFS_STATUS, status);
			if (status[31:16] != want[31:16])
				stop_on_timeout({check_name, ": counters never reached the expected values"});
			// second read lets task_done clear the masks first
			read_reg(1'b0, OFS_STATUS, status);
			read_reg(1'b1, OFS_MISMATCH, mm_reg);
			checks += 6;
			if (status[15:0] !== want[15:0]) report_fail("checkin_mask", status[15:0], want[15:0]);
			if (status[23:16] !== want[23:16])
				report_fail("match_count", status[23:16], want[23:16]);
			if (status[31:24] !== want[31:24])
				report_fail("mismatch_count", status[31:24], want[31:24]);
			if (mm_reg[3:0] !== want[35:32])
				report_fail("last_mismatch_task", mm_reg[3:0], want[35:32]);
			if (mm_reg[8] !== want[40]) report_fail("mismatch_flag", mm_reg[8], want[40]);
			if (mismatch !== want[40]) report_fail("mismatch", mismatch, want[40]);
			check_req = 1'b0;
		end
	end

	initial begin
		task_id_t t;
		fprint_t  fa;
		fprint_t  fb;
		fprint_t  burst [STORE_DEPTH];
		void'($urandom(32'he59df730));
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		request_check("after reset");

		// matching pair, both checkins land before the compare
		t  = task_id_t'($urandom_range(15, 0));
		fa = $urandom;
		checkout(1'b0, t);
		checkout(1'b1, t);
		send_fprint(1'b0, t, fa);
		checkin(1'b0, t);
		checkin(1'b1, t);
		send_fprint(1'b1, t, fa);
		request_check("matching pair");

		t  = task_id_t'($urandom_range(15, 0));
		fa = $urandom;
		fb = fa ^ ($urandom | 32'h1); // at least one bit differs
		checkout(1'b0, t);
		checkout(1'b1, t);
		send_fprint(1'b0, t, fa);
		send_fprint(1'b1, t, fb);
		request_check("mismatching pair");

		// nothing checked out, so all of this is dropped
		t  = task_id_t'($urandom_range(15, 0));
		fa = $urandom;
		send_fprint(1'b0, t, fa);
		send_fprint(1'b1, t, fa);
		checkin(1'b0, t);
		checkin(1'b1, t);
		request_check("checkout gating");

		t  = task_id_t'($urandom_range(15, 0));
		fa = $urandom;
		checkout(1'b0, t);
		checkout(1'b1, t);
		checkin(1'b0, t);
		checkin(1'b1, t);
		request_check("checkin mask set");
		send_fprint(1'b0, t, fa);
		send_fprint(1'b1, t, fa);
		request_check("checkin mask cleared");

		// core 0 can run ahead by one full store before it blocks the shared fifo
		for (int k = 0; k < STORE_DEPTH; k++) begin
			checkout(1'b0, task_id_t'(k));
			checkout(1'b1, task_id_t'(k));
		end
		for (int k = 0; k < STORE_DEPTH; k++) begin
			burst[k] = $urandom;
			send_fprint(1'b0, task_id_t'(k), burst[k]);
		end
		request_check("core 0 store full");
		for (int k = 0; k < STORE_DEPTH; k++)
			send_fprint(1'b1, task_id_t'(k), burst[k]);
		request_check("back-pressure drained");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/fprint_pkg.sv
`default_nettype none

package fprint_pkg;

	// bus and datapath widths
	localparam int DATA_W      = 32;
	localparam int ADDR_W      = 8;
	localparam int TASK_W      = 4;
	localparam int NUM_TASKS   = 16;
	localparam int HALF_W      = 16;
	localparam int FPRINT_W    = 32;
	localparam int NUM_CORES   = 2;
	localparam int STORE_DEPTH = 8;
	localparam int FIFO_DEPTH  = 8;
	localparam int COUNT_W     = 8;

	// pointer and occupancy widths
	localparam int STORE_PTR_W = $clog2(STORE_DEPTH);
	localparam int STORE_CNT_W = $clog2(STORE_DEPTH + 1);
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

	// register offsets within a core window, paddr[3:0]
	localparam logic [3:0] OFS_CS       = 4'd0;
	localparam logic [3:0] OFS_FPRINT   = 4'd1;
	localparam logic [3:0] OFS_STATUS   = 4'd2;
	localparam logic [3:0] OFS_MISMATCH = 4'd3;

	typedef logic [TASK_W-1:0]              task_id_t;
	typedef logic [HALF_W-1:0]              half_t;
	typedef logic [FPRINT_W-1:0]            fprint_t;
	typedef logic [COUNT_W-1:0]             count_t;
	typedef logic [NUM_TASKS-1:0]           task_mask_t;
	typedef logic [$clog2(NUM_CORES)-1:0]   core_t;
	typedef logic [HALF_W+TASK_W+1:0]       fifo_word_t; // {block, core, task, half}

	typedef enum logic [1:0] {DRAIN_IDLE, DRAIN_READ, DRAIN_ROUTE} drain_state_t;
	typedef enum logic [1:0] {COMP_IDLE, COMP_CHECK, COMP_DONE} comp_state_t;

endpackage

`default_nettype wire

// File: fprint_store/fprint_store.sv
`default_nettype none

module fprint_store import fprint_pkg::*; (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire logic     wr_en,
	input  wire logic     wr_block,
	input  wire task_id_t wr_task,
	input  wire half_t    wr_half,
	input  wire logic     pop,
	output logic          entry_valid,
	output task_id_t      entry_task,
	output fprint_t       entry_fprint,
	output logic          full
);

	// entries kept as separate low and high half arrays
	half_t                  mem_lo [STORE_DEPTH];
	half_t                  mem_hi [STORE_DEPTH];
	task_id_t               mem_task [STORE_DEPTH];
	half_t                  lo_latch;
	logic [STORE_PTR_W-1:0] head;
	logic [STORE_PTR_W-1:0] tail;
	logic [STORE_CNT_W-1:0] count;
	logic                   push;
	logic                   deq;

	assign push = wr_en && wr_block; // high half completes the entry
	assign deq  = pop && entry_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) head <= head + 1'b1;
			if (deq) tail <= tail + 1'b1;
			case ({push, deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !wr_block)
			lo_latch <= wr_half;
		if (push) begin
			mem_lo[head]   <= lo_latch;
			mem_hi[head]   <= wr_half;
			mem_task[head] <= wr_task;
		end
	end

	// valid follows the count, so it rises the cycle after the high half
	assign entry_valid  = (count != '0);
	assign entry_task   = mem_task[tail];
	assign entry_fprint = {mem_hi[tail], mem_lo[tail]};
	assign full         = (count == STORE_CNT_W'(STORE_DEPTH));

endmodule

`default_nettype wire

// File: source/fprint_apb_front.sv
`default_nettype none

module fprint_apb_front import fprint_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              psel,
	input  wire logic              penable,
	input  wire logic              pwrite,
	input  wire logic [ADDR_W-1:0] paddr,
	input  wire logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0]      prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  wire logic [NUM_CORES-1:0] store_full,
	output logic [NUM_CORES-1:0]   store_wr_en,
	output half_t                  store_wr_half,
	output logic                   store_wr_block,
	output task_id_t               store_wr_task,
	input  wire logic              task_done,
	input  wire task_id_t          done_task,
	input  wire count_t            match_count,
	input  wire count_t            mismatch_count,
	input  wire task_id_t          last_mismatch_task,
	input  wire logic              mismatch
);

	task_mask_t    checkout_mask [NUM_CORES];
	task_mask_t    checkin_mask [NUM_CORES];
	logic          access;
	logic          wr_cs;
	logic          fp_accept;
	core_t         wr_core;
	task_id_t      wr_task;
	fifo_word_t    fifo_wr_data;
	fifo_word_t    fifo_rd_data;
	logic          fifo_rd_en;
	logic          fifo_empty;
	logic          fifo_full;
	logic          fifo_block;
	core_t         fifo_core;
	task_id_t      fifo_task;
	half_t         fifo_half;
	logic          route_go;
	drain_state_t  drain_state;
	drain_state_t  drain_next;

	assign access  = psel && penable;
	assign wr_core = paddr[4]; // logical core window
	assign wr_task = pwdata[TASK_W-1:0];
	assign wr_cs   = access && pwrite && (paddr[3:0] == OFS_CS);

	// halves for a task not checked out are dropped here
	assign fp_accept = access && pwrite && (paddr[3:0] == OFS_FPRINT)
		&& checkout_mask[wr_core][wr_task];

	assign pready  = access && !(fp_accept && fifo_full); // stall only a queued write
	assign pslverr = 1'b0;

	assign fifo_wr_data = {pwdata[5], wr_core, wr_task, pwdata[DATA_W-1:HALF_W]};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int c = 0; c < NUM_CORES; c++) begin
				checkout_mask[c] <= '0;
				checkin_mask[c]  <= '0;
			end
		end else begin
			if (wr_cs) begin
				if (pwdata[4])
					checkout_mask[wr_core][wr_task] <= 1'b1;
				else if (checkout_mask[wr_core][wr_task])
					checkin_mask[wr_core][wr_task] <= 1'b1;
			end
			// completion wins over a write to the same task
			if (task_done) begin
				for (int c = 0; c < NUM_CORES; c++) begin
					checkout_mask[c][done_task] <= 1'b0;
					checkin_mask[c][done_task]  <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr[3:0])
				OFS_STATUS:   prdata = {mismatch_count, match_count,
					checkin_mask[0] & checkin_mask[1]};
				OFS_MISMATCH: begin
					prdata[TASK_W-1:0] = last_mismatch_task;
					prdata[8]          = mismatch;
				end
				default: ;
			endcase
		end
	end

	fprint_fifo u_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_data (fifo_wr_data),
		.wr_en   (fp_accept && !fifo_full),
		.rd_en   (fifo_rd_en),
		.rd_data (fifo_rd_data),
		.empty   (fifo_empty),
		.full    (fifo_full)
	);

	assign {fifo_block, fifo_core, fifo_task, fifo_half} = fifo_rd_data;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) drain_state <= DRAIN_IDLE;
		else drain_state <= drain_next;
	end

	always_comb begin
		drain_next = drain_state;
		case (drain_state)
			DRAIN_IDLE:  if (!fifo_empty) drain_next = DRAIN_READ;
			DRAIN_READ:  drain_next = DRAIN_ROUTE;
			DRAIN_ROUTE: if (!store_full[fifo_core]) drain_next = DRAIN_IDLE; // hold while full
			default:     drain_next = DRAIN_IDLE;
		endcase
	end

	assign fifo_rd_en = (drain_state == DRAIN_READ);
	assign route_go   = (drain_state == DRAIN_ROUTE) && !store_full[fifo_core];

	always_comb begin
		for (int c = 0; c < NUM_CORES; c++)
			store_wr_en[c] = route_go && (fifo_core == core_t'(c));
	end

	assign store_wr_half  = fifo_half;
	assign store_wr_block = fifo_block;
	assign store_wr_task  = fifo_task;

endmodule

`default_nettype wire

// File: source/fprint_comparator.sv
`default_nettype none

module fprint_comparator import fprint_pkg::*; (
	input  wire logic           clk,
	input  wire logic           reset,
	input  wire logic [NUM_CORES-1:0] entry_valid,
	input  wire task_id_t       entry_task [NUM_CORES],
	input  wire fprint_t        entry_fprint [NUM_CORES],
	output logic [NUM_CORES-1:0] pop,
	output logic                task_done,
	output task_id_t            done_task,
	output count_t              match_count,
	output count_t              mismatch_count,
	output task_id_t            last_mismatch_task,
	output logic                mismatch
);

	comp_state_t state;
	fprint_t     fprint_a;
	fprint_t     fprint_b;
	task_id_t    task_a;
	task_id_t    task_b;
	logic        same;

	// a pair only matches when both the task and the fingerprint agree
	assign same = (fprint_a == fprint_b) && (task_a == task_b);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state              <= COMP_IDLE;
			match_count        <= '0;
			mismatch_count     <= '0;
			last_mismatch_task <= '0;
			mismatch           <= 1'b0;
		end else begin
			case (state)
				COMP_IDLE: if (&entry_valid) state <= COMP_CHECK;
				COMP_CHECK: begin
					if (same) begin
						if (match_count != '1) match_count <= match_count + 1'b1;
					end else begin
						if (mismatch_count != '1) mismatch_count <= mismatch_count + 1'b1;
						last_mismatch_task <= task_a; // core 0 view of the task
						mismatch           <= 1'b1;   // sticky until reset
					end
					state <= COMP_DONE;
				end
				COMP_DONE: state <= COMP_IDLE;
				default:   state <= COMP_IDLE;
			endcase
		end
	end

	// capture both heads when leaving idle
	always_ff @(posedge clk) begin
		if (state == COMP_IDLE && (&entry_valid)) begin
			fprint_a <= entry_fprint[0];
			fprint_b <= entry_fprint[1];
			task_a   <= entry_task[0];
			task_b   <= entry_task[1];
		end
	end

	assign pop       = {NUM_CORES{state == COMP_CHECK}}; // both stores dequeue together
	assign task_done = (state == COMP_DONE);
	assign done_task = task_a;

endmodule

`default_nettype wire

// File: source/fprint_fifo.sv
`default_nettype none

module fprint_fifo import fprint_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire fifo_word_t wr_data,
	input  wire logic       wr_en,
	input  wire logic       rd_en,
	output fifo_word_t      rd_data,
	output logic            empty,
	output logic            full
);

	fifo_word_t              mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]   wr_ptr;
	logic [FIFO_PTR_W-1:0]   rd_ptr;
	logic [FIFO_CNT_W-1:0]   count;
	logic                    push;
	logic                    pop;

	assign push  = wr_en && !full;
	assign pop   = rd_en && !empty;
	assign empty = (count == '0);
	assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// read data shows up one cycle after rd_en
	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= wr_data;
		if (pop) rd_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: source/fprint_unit_top.sv
`default_nettype none

module fprint_unit_top import fprint_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              psel,
	input  wire logic              penable,
	input  wire logic              pwrite,
	input  wire logic [ADDR_W-1:0] paddr,
	input  wire logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0]      prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   mismatch
);

	logic [NUM_CORES-1:0] store_wr_en;
	logic [NUM_CORES-1:0] store_full;
	half_t                store_wr_half;
	logic                 store_wr_block;
	task_id_t             store_wr_task;
	logic [NUM_CORES-1:0] entry_valid;
	task_id_t             entry_task [NUM_CORES];
	fprint_t              entry_fprint [NUM_CORES];
	logic [NUM_CORES-1:0] pop;
	logic                 task_done;
	task_id_t             done_task;
	count_t               match_count;
	count_t               mismatch_count;
	task_id_t             last_mismatch_task;

	fprint_apb_front u_front (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.store_full, .store_wr_en, .store_wr_half, .store_wr_block, .store_wr_task,
		.task_done, .done_task, .match_count, .mismatch_count,
		.last_mismatch_task, .mismatch
	);

	// one store per logical core
	for (genvar i = 0; i < NUM_CORES; i++) begin : g_store
		fprint_store u_store (
			.clk          (clk),
			.reset        (reset),
			.wr_en        (store_wr_en[i]),
			.wr_block     (store_wr_block),
			.wr_task      (store_wr_task),
			.wr_half      (store_wr_half),
			.pop          (pop[i]),
			.entry_valid  (entry_valid[i]),
			.entry_task   (entry_task[i]),
			.entry_fprint (entry_fprint[i]),
			.full         (store_full[i])
		);
	end

	fprint_comparator u_comp (
		.clk, .reset, .entry_valid, .entry_task, .entry_fprint, .pop,
		.task_done, .done_task, .match_count, .mismatch_count,
		.last_mismatch_task, .mismatch
	);

endmodule

`default_nettype wire

// File: sources.f
common/fprint_pkg.sv
source/fprint_fifo.sv
source/fprint_apb_front.sv
fprint_store/fprint_store.sv
source/fprint_comparator.sv
source/fprint_unit_top.sv
bench/fprint_unit_sva.sv
bench/fprint_unit_tb.sv
